// File: all.f
rtl/fm_pkg.sv
rtl/fm_mmr.sv
rtl/fm_param_store.sv
rtl/fm_timers.sv
rtl/fm_ctrl_top.sv
verification/fm_ctrl_tb.sv

// File: Bender.yml
package:
  name: fm_ctrl

sources:
  - rtl/fm_pkg.sv
  - rtl/fm_mmr.sv
  - rtl/fm_param_store.sv
  - rtl/fm_timers.sv
  - rtl/fm_ctrl_top.sv
  - target: test
    files:
      - verification/fm_ctrl_tb.sv

// File: verification/fm_ctrl_tb.sv
// ####################################################################
// fm control testbench: directed tests of writes, stream, timers, divider
// ####################################################################
`timescale 1ns/100ps
`default_nettype none

module fm_ctrl_tb;

	localparam int BUSY         = 32;
	localparam int PRESCALE     = 16;
	localparam int WRITE_CYCLES = 2 * (BUSY + 3); // address byte plus data byte
	localparam int NUM_WRITES   = 60;
	localparam int SLOT_EVENTS  = 6 * fm_pkg::num_slots + 120; // scans and timer waits
	localparam int TIMEOUT_CYCLES = 3 * (NUM_WRITES * WRITE_CYCLES + 6 * SLOT_EVENTS);

	logic                clk;
	logic                rst;
	logic                cen;
	fm_pkg::host_wr_t    wr;
	logic                wr_valid;
	logic                wr_ready;
	fm_pkg::slot_out_t   slot_out;
	logic                slot_valid;
	fm_pkg::timer_stat_t stat;
	logic                irq;

	int          cycles    = 0;
	int          slot_seen = 0;
	int          slot_errs = 0;
	int          stat_errs = 0;
	int          bit_errs  = 0;
	logic [31:0] rng_state = 32'hd673_b9cd;

	// reference model of the voice registers
	fm_pkg::op_params_t           op_model [fm_pkg::num_slots];
	fm_pkg::ch_params_t           ch_model [fm_pkg::num_ch];
	logic [fm_pkg::num_slots-1:0] key_model;

	fm_pkg::slot_out_t seen_q[$];
	int                seen_idx_q[$];

	fm_ctrl_top #(
		.BUSY_CYCLES      (BUSY),
		.TIMER_B_PRESCALE (PRESCALE)
	) u_fm_ctrl_top (
		.clk        (clk),
		.rst        (rst),
		.cen        (cen),
		.wr         (wr),
		.wr_valid   (wr_valid),
		.wr_ready   (wr_ready),
		.slot_out   (slot_out),
		.slot_valid (slot_valid),
		.stat       (stat),
		.irq        (irq)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// slot k after reset is scanner index k mod 24
	always @(negedge clk) begin
		if (!rst && slot_valid) begin
			seen_q.push_back(slot_out);
			seen_idx_q.push_back(slot_seen % fm_pkg::num_slots);
			slot_seen++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: no handshake or slot pulse within %0d cycles", TIMEOUT_CYCLES);
			$display("errors: slot %0d, status %0d, bit %0d", slot_errs, stat_errs, bit_errs);
			$display("tests failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic fm_pkg::slot_out_t expected_slot(input int idx);
		fm_pkg::slot_out_t e;
		e.ch    = 3'(idx / fm_pkg::num_op);
		e.op    = 2'(idx % fm_pkg::num_op);
		e.keyon = key_model[idx];
		e.opp   = op_model[idx];
		e.chp   = ch_model[idx / fm_pkg::num_op];
		return e;
	endfunction

	function automatic fm_pkg::timer_stat_t stat_of(input logic a, input logic b);
		fm_pkg::timer_stat_t s;
		s.flag_a = a;
		s.flag_b = b;
		return s;
	endfunction

	task automatic check_slot(input fm_pkg::slot_out_t got, input fm_pkg::slot_out_t exp,
		input string what);
		if (got !== exp) begin
			slot_errs++;
			$display("[FAIL] %0t: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_stat(input fm_pkg::timer_stat_t got, input fm_pkg::timer_stat_t exp,
		input string what);
		if (got !== exp) begin
			stat_errs++;
			$display("[FAIL] %0t: %s, got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			bit_errs++;
			$display("[FAIL] %0t: %s, got %b expected %b", $time, what, got, exp);
		end
	endtask

	// one host byte, returns on the falling edge after the transfer
	task automatic xfer(input logic is_data, input logic bank, input logic [7:0] d);
		@(negedge clk);
		wr.is_data = is_data;
		wr.bank    = bank;
		wr.data    = d;
		wr_valid   = 1'b1;
		while (!wr_ready)
			@(negedge clk);
		@(negedge clk);
		wr_valid = 1'b0;
	endtask

	// register map rules applied to the model
	task automatic model_write(input logic bank, input logic [7:0] a, input logic [7:0] d);
		int ch;
		int idx;
		if (a == fm_pkg::key_on) begin
			if (d[1:0] != 2'b11) begin
				ch = (d[2] ? 3 : 0) + d[1:0];
				for (int i = 0; i < fm_pkg::num_op; i++)
					key_model[ch * fm_pkg::num_op + i] = d[4 + i];
			end
		end else if (a[1:0] != 2'b11) begin
			ch  = (bank ? 3 : 0) + a[1:0];
			idx = ch * fm_pkg::num_op + a[3:2];
			case (a[7:4])
				4'h3: {op_model[idx].dt1, op_model[idx].mul} = {d[6:4], d[3:0]};
				4'h4: op_model[idx].tl = d[6:0];
				4'h5: {op_model[idx].ks, op_model[idx].ar} = {d[7:6], d[4:0]};
				4'h6: op_model[idx].d1r = d[4:0];
				4'h7: op_model[idx].d2r = d[4:0];
				4'h8: {op_model[idx].d1l, op_model[idx].rr} = d;
				4'hA: begin
					if (a[3:2] == 2'd0)
						ch_model[ch].fnum[7:0] = d;
					else if (a[3:2] == 2'd1)
						{ch_model[ch].block, ch_model[ch].fnum[10:8]} = d[5:0];
				end
				4'hB: if (a[3:2] == 2'd0) {ch_model[ch].fb, ch_model[ch].alg} = d[5:0];
				default: ;
			endcase
		end
	endtask

	task automatic write_reg(input logic bank, input logic [7:0] a, input logic [7:0] d);
		xfer(1'b0, bank, a);
		xfer(1'b1, bank, d);
		model_write(bank, a, d);
	endtask

	task automatic wait_slots(input int target);
		while (slot_seen < target)
			@(posedge clk);
	endtask

	// one full rotation compared against the model
	task automatic scan_and_compare(input string what);
		repeat (4) @(negedge clk); // last update reaches the store
		@(posedge clk);
		seen_q.delete();
		seen_idx_q.delete();
		while (seen_q.size() < fm_pkg::num_slots)
			@(posedge clk);
		for (int i = 0; i < fm_pkg::num_slots; i++)
			check_slot(seen_q[i], expected_slot(seen_idx_q[i]),
				$sformatf("%s slot %0d", what, seen_idx_q[i]));
	endtask

	task automatic test_reset_state();
		@(negedge clk);
		check_bit(wr_ready, 1'b1, "ready after reset");
		check_bit(irq, 1'b0, "irq after reset");
		check_stat(stat, stat_of(1'b0, 1'b0), "flags after reset");
		scan_and_compare("reset");
	endtask

	task automatic test_busy_window();
		xfer(1'b0, 1'b0, fm_pkg::timer_b);
		check_bit(wr_ready, 1'b1, "ready after address byte");
		xfer(1'b1, 1'b0, 8'h00);
		for (int k = 0; k < BUSY; k++) begin
			check_bit(wr_ready, 1'b0, $sformatf("ready in busy cycle %0d", k));
			@(negedge clk);
		end
		check_bit(wr_ready, 1'b1, "ready at end of busy window");
	endtask

	task automatic test_op_params();
		logic       bank_sel [4] = '{1'b0, 1'b1, 1'b1, 1'b0};
		logic [1:0] lo_sel   [4] = '{2'd1, 2'd0, 2'd2, 2'd0};
		logic [1:0] op_sel   [4] = '{2'd2, 2'd1, 2'd3, 2'd0};
		logic [7:0] a;
		for (int s = 0; s < 4; s++) begin
			for (int base = 3; base <= 8; base++) begin
				a = {4'(base), op_sel[s], lo_sel[s]};
				write_reg(bank_sel[s], a, 8'(xorshift32()));
			end
		end
		scan_and_compare("operator params");
	endtask

	task automatic test_ch_params_key_on();
		logic [3:0] bits;
		bits = 4'(xorshift32());
		write_reg(1'b1, 8'hA1, 8'(xorshift32())); // channel 4
		write_reg(1'b1, 8'hA5, 8'(xorshift32()));
		write_reg(1'b1, 8'hB1, 8'(xorshift32()));
		write_reg(1'b0, fm_pkg::key_on, {bits, 4'b0101});
		write_reg(1'b0, fm_pkg::key_on, 8'hF3); // unused codes
		write_reg(1'b0, fm_pkg::key_on, 8'hF7);
		scan_and_compare("channel params and key-on");
	endtask

	task automatic test_timers();
		int start;
		write_reg(1'b0, fm_pkg::timer_a_hi, 8'hFF); // value 1020
		write_reg(1'b0, fm_pkg::timer_a_lo, 8'h00);
		write_reg(1'b0, fm_pkg::timer_ctl, 8'h05);
		@(posedge clk);
		start = slot_seen;
		wait_slots(start + 3);
		@(negedge clk);
		check_stat(stat, stat_of(1'b0, 1'b0), "timer A before overflow");
		wait_slots(start + 4);
		repeat (2) @(negedge clk);
		check_stat(stat, stat_of(1'b1, 1'b0), "timer A overflow");
		check_bit(irq, 1'b1, "irq from timer A");
		write_reg(1'b0, fm_pkg::timer_ctl, 8'h10); // clear A, stop A
		@(negedge clk);
		check_stat(stat, stat_of(1'b0, 1'b0), "timer A clear");
		check_bit(irq, 1'b0, "irq after clear A");

		write_reg(1'b0, fm_pkg::timer_b, 8'hFE);
		write_reg(1'b0, fm_pkg::timer_ctl, 8'h0A);
		@(posedge clk);
		start = slot_seen;
		wait_slots(start + 2 * PRESCALE - 1);
		@(negedge clk);
		check_stat(stat, stat_of(1'b0, 1'b0), "timer B before overflow");
		wait_slots(start + 2 * PRESCALE);
		repeat (2) @(negedge clk);
		check_stat(stat, stat_of(1'b0, 1'b1), "timer B overflow");
		check_bit(irq, 1'b1, "irq from timer B");

		write_reg(1'b0, fm_pkg::timer_ctl, 8'h22); // clear B, irq B off
		@(negedge clk);
		check_stat(stat, stat_of(1'b0, 1'b0), "timer B clear");
		@(posedge clk);
		start = slot_seen;
		wait_slots(start + 40);
		@(negedge clk);
		check_stat(stat, stat_of(1'b0, 1'b0), "timer B with irq disabled");
		check_bit(irq, 1'b0, "irq with irq B disabled");
		write_reg(1'b0, fm_pkg::timer_ctl, 8'h00);
	endtask

	task automatic check_period(input int n, input string what);
		repeat (2) begin // skip one pulse so the new ratio holds
			@(negedge clk);
			while (!slot_valid)
				@(negedge clk);
		end
		repeat (3) begin
			for (int k = 1; k < n; k++) begin
				@(negedge clk);
				check_bit(slot_valid, 1'b0, $sformatf("%s gap", what));
			end
			@(negedge clk);
			check_bit(slot_valid, 1'b1, $sformatf("%s pulse", what));
		end
	endtask

	task automatic test_divider();
		check_period(6, "divide by 6");
		write_reg(1'b0, fm_pkg::div_3, 8'h00);
		check_period(3, "divide by 3");
		write_reg(1'b0, fm_pkg::div_2, 8'h00);
		check_period(2, "divide by 2");
	endtask

	initial begin
		rst       = 1'b1;
		cen       = 1'b1;
		wr        = '0;
		wr_valid  = 1'b0;
		key_model = '0;
		for (int i = 0; i < fm_pkg::num_slots; i++)
			op_model[i] = '0;
		for (int j = 0; j < fm_pkg::num_ch; j++)
			ch_model[j] = '0;
		repeat (5) @(negedge clk);
		rst = 1'b0;

		test_reset_state();
		test_busy_window();
		test_op_params();
		test_ch_params_key_on();
		test_timers();
		test_divider();

		$display("errors: slot %0d, status %0d, bit %0d", slot_errs, stat_errs, bit_errs);
		if (slot_errs + stat_errs + bit_errs == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/fm_ctrl_top.sv
// ####################################################################
// fm control top: decoder, parameter store and timers
// ####################################################################
`timescale 1ns/100ps
`default_nettype none

module fm_ctrl_top #(
	parameter int BUSY_CYCLES      = 32,
	parameter int TIMER_B_PRESCALE = 16
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                cen,
	input  fm_pkg::host_wr_t    wr,
	input  logic                wr_valid,
	output logic                wr_ready,
	output fm_pkg::slot_out_t   slot_out,
	output logic                slot_valid,
	output fm_pkg::timer_stat_t stat,
	output logic                irq
);

	logic               clk_en;
	fm_pkg::param_upd_t upd;
	logic               upd_valid;
	logic [2:0]         kon_ch;
	logic [3:0]         kon_bits;
	logic               kon_valid;
	fm_pkg::timer_cfg_t tcfg;

	fm_mmr #(
		.BUSY_CYCLES (BUSY_CYCLES)
	) u_mmr (
		.clk       (clk),
		.rst       (rst),
		.cen       (cen),
		.wr        (wr),
		.wr_valid  (wr_valid),
		.wr_ready  (wr_ready),
		.clk_en    (clk_en),
		.upd       (upd),
		.upd_valid (upd_valid),
		.kon_ch    (kon_ch),
		.kon_bits  (kon_bits),
		.kon_valid (kon_valid),
		.tcfg      (tcfg)
	);

	fm_param_store u_param_store (
		.clk        (clk),
		.rst        (rst),
		.clk_en     (clk_en),
		.upd        (upd),
		.upd_valid  (upd_valid),
		.kon_ch     (kon_ch),
		.kon_bits   (kon_bits),
		.kon_valid  (kon_valid),
		.slot_out   (slot_out),
		.slot_valid (slot_valid)
	);

	fm_timers #(
		.TIMER_B_PRESCALE (TIMER_B_PRESCALE)
	) u_timers (
		.clk    (clk),
		.rst    (rst),
		.clk_en (clk_en),
		.tcfg   (tcfg),
		.stat   (stat),
		.irq    (irq)
	);

endmodule

`default_nettype wire

// File: rtl/fm_timers.sv
// ####################################################################
// fm timers: timer A and B counters, overflow flags and interrupt
// ####################################################################
`timescale 1ns/100ps
`default_nettype none

module fm_timers #(
	parameter int TIMER_B_PRESCALE = 16
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                clk_en,
	input  fm_pkg::timer_cfg_t  tcfg,
	output fm_pkg::timer_stat_t stat,
	output logic                irq
);

	localparam int PRE_W = $clog2(TIMER_B_PRESCALE + 1);

	logic [9:0]       cnt_a;
	logic [7:0]       cnt_b;
	logic [PRE_W-1:0] pre_cnt;
	logic             tick_b;
	logic             ovf_a;
	logic             ovf_b;

	assign tick_b = clk_en && (pre_cnt == PRE_W'(TIMER_B_PRESCALE - 1));
	assign ovf_a  = tcfg.load_a && clk_en && (cnt_a == 10'h3FF);
	assign ovf_b  = tcfg.load_b && tick_b && (cnt_b == 8'hFF);

	// timer A, held at its start value while stopped
	always_ff @(posedge clk) begin
		if (rst)
			cnt_a <= 10'd0;
		else if (!tcfg.load_a)
			cnt_a <= tcfg.value_a;
		else if (clk_en)
			cnt_a <= ovf_a ? tcfg.value_a : cnt_a + 10'd1;
	end

	// timer B behind its prescaler
	always_ff @(posedge clk) begin
		if (rst) begin
			pre_cnt <= '0;
			cnt_b   <= 8'd0;
		end else if (!tcfg.load_b) begin
			pre_cnt <= '0;
			cnt_b   <= tcfg.value_b;
		end else if (clk_en) begin
			pre_cnt <= tick_b ? '0 : pre_cnt + 1'b1;
			if (tick_b)
				cnt_b <= ovf_b ? tcfg.value_b : cnt_b + 8'd1;
		end
	end

	// sticky flags, clear wins over a new overflow
	always_ff @(posedge clk) begin
		if (rst) begin
			stat <= '0;
		end else begin
			if (tcfg.clr_a)
				stat.flag_a <= 1'b0;
			else if (ovf_a && tcfg.en_irq_a)
				stat.flag_a <= 1'b1;
			if (tcfg.clr_b)
				stat.flag_b <= 1'b0;
			else if (ovf_b && tcfg.en_irq_b)
				stat.flag_b <= 1'b1;
		end
	end

	assign irq = stat.flag_a | stat.flag_b;

endmodule

`default_nettype wire

// File: rtl/fm_param_store.sv
// ####################################################################
// fm parameter store: voice memory, key bits and rotating slot stream
// ####################################################################
`timescale 1ns/100ps
`default_nettype none

module fm_param_store (
	input  logic               clk,
	input  logic               rst,
	input  logic               clk_en,
	input  fm_pkg::param_upd_t upd,
	input  logic               upd_valid,
	input  logic [2:0]         kon_ch,
	input  logic [3:0]         kon_bits,
	input  logic               kon_valid,
	output fm_pkg::slot_out_t  slot_out,
	output logic               slot_valid
);

	fm_pkg::op_params_t            op_mem [fm_pkg::num_slots];
	fm_pkg::ch_params_t            ch_mem [fm_pkg::num_ch];
	logic [fm_pkg::num_slots-1:0]  key;
	logic [4:0]                    upd_idx;
	logic [2:0]                    slot_ch;
	logic [1:0]                    slot_op;

	assign upd_idx = {upd.ch, upd.op}; // ch*4 + op

	// field writes, each touching only its own bits
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < fm_pkg::num_slots; i++)
				op_mem[i] <= '0;
			for (int j = 0; j < fm_pkg::num_ch; j++)
				ch_mem[j] <= '0;
			key <= '0;
		end else begin
			if (upd_valid) begin
				case (upd.field)
					fm_pkg::fld_dt1_mul: begin
						op_mem[upd_idx].dt1 <= upd.data[6:4];
						op_mem[upd_idx].mul <= upd.data[3:0];
					end
					fm_pkg::fld_tl: op_mem[upd_idx].tl <= upd.data[6:0];
					fm_pkg::fld_ks_ar: begin
						op_mem[upd_idx].ks <= upd.data[7:6];
						op_mem[upd_idx].ar <= upd.data[4:0];
					end
					fm_pkg::fld_d1r: op_mem[upd_idx].d1r <= upd.data[4:0];
					fm_pkg::fld_d2r: op_mem[upd_idx].d2r <= upd.data[4:0];
					fm_pkg::fld_d1l_rr: begin
						op_mem[upd_idx].d1l <= upd.data[7:4];
						op_mem[upd_idx].rr  <= upd.data[3:0];
					end
					fm_pkg::fld_fnum_lo: ch_mem[upd.ch].fnum[7:0] <= upd.data;
					fm_pkg::fld_block_fnum_hi: begin
						ch_mem[upd.ch].block      <= upd.data[5:3];
						ch_mem[upd.ch].fnum[10:8] <= upd.data[2:0];
					end
					fm_pkg::fld_fb_alg: begin
						ch_mem[upd.ch].fb  <= upd.data[5:3];
						ch_mem[upd.ch].alg <= upd.data[2:0];
					end
					default: ;
				endcase
			end
			if (kon_valid)
				key[{kon_ch, 2'b00} +: 4] <= kon_bits; // bit i is operator i
		end
	end

	// slot scanner, channel outer and operator inner
	always_ff @(posedge clk) begin
		if (rst) begin
			slot_ch    <= 3'd0;
			slot_op    <= 2'd0;
			slot_valid <= 1'b0;
		end else begin
			slot_valid <= clk_en;
			if (clk_en) begin
				if (slot_op == 2'(fm_pkg::num_op - 1)) begin
					slot_op <= 2'd0;
					slot_ch <= (slot_ch == 3'(fm_pkg::num_ch - 1)) ? 3'd0 : slot_ch + 3'd1;
				end else begin
					slot_op <= slot_op + 2'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (clk_en) begin
			slot_out.ch    <= slot_ch;
			slot_out.op    <= slot_op;
			slot_out.keyon <= key[{slot_ch, slot_op}];
			slot_out.opp   <= op_mem[{slot_ch, slot_op}];
			slot_out.chp   <= ch_mem[slot_ch];
		end
	end

endmodule

`default_nettype wire

// File: rtl/fm_mmr.sv
// ####################################################################
// fm register decoder: host writes, busy window, clock-enable divider
// ####################################################################
`timescale 1ns/100ps
`default_nettype none

module fm_mmr #(
	parameter int BUSY_CYCLES = 32
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                cen,
	input  fm_pkg::host_wr_t    wr,
	input  logic                wr_valid,
	output logic                wr_ready,
	output logic                clk_en,
	output fm_pkg::param_upd_t  upd,
	output logic                upd_valid,
	output logic [2:0]          kon_ch,
	output logic [3:0]          kon_bits,
	output logic                kon_valid,
	output fm_pkg::timer_cfg_t  tcfg
);

	localparam int BUSY_W = $clog2(BUSY_CYCLES + 1);

	logic [7:0]           sel_reg;
	logic                 addr_xfer;
	logic                 data_xfer;
	fm_pkg::div_e         div;
	logic [2:0]           cen_cnt;
	logic [2:0]           cen_lim;
	logic [BUSY_W-1:0]    busy_cnt;
	fm_pkg::param_field_e field;

	// channel index from a bank bit and the low two register bits
	function automatic logic [2:0] bank_ch(input logic hi, input logic [1:0] lo);
		return hi ? 3'd3 + {1'b0, lo} : {1'b0, lo};
	endfunction

	// voice register address to parameter field
	function automatic fm_pkg::param_field_e voice_field(input logic [7:0] a);
		fm_pkg::param_field_e f;
		f = fm_pkg::fld_none;
		if (a[1:0] != 2'b11) begin
			case (a[7:4])
				4'h3: f = fm_pkg::fld_dt1_mul;
				4'h4: f = fm_pkg::fld_tl;
				4'h5: f = fm_pkg::fld_ks_ar;
				4'h6: f = fm_pkg::fld_d1r;
				4'h7: f = fm_pkg::fld_d2r;
				4'h8: f = fm_pkg::fld_d1l_rr;
				4'hA: begin
					if (a[3:2] == 2'b00)
						f = fm_pkg::fld_fnum_lo;
					else if (a[3:2] == 2'b01)
						f = fm_pkg::fld_block_fnum_hi;
				end
				4'hB: begin
					if (a[3:2] == 2'b00)
						f = fm_pkg::fld_fb_alg;
				end
				default: f = fm_pkg::fld_none;
			endcase
		end
		return f;
	endfunction

	assign addr_xfer = wr_valid & wr_ready & ~wr.is_data;
	assign data_xfer = wr_valid & wr_ready & wr.is_data;
	assign field     = voice_field(sel_reg);

	always_comb begin
		case (div)
			fm_pkg::div_by_3: cen_lim = 3'd2;
			fm_pkg::div_by_2: cen_lim = 3'd1;
			default:          cen_lim = 3'd5;
		endcase
	end

	// cen divider, clk_en one cycle after the wrap
	always_ff @(posedge clk) begin
		if (rst) begin
			cen_cnt <= 3'd0;
			clk_en  <= 1'b0;
		end else begin
			clk_en <= cen && (cen_cnt >= cen_lim);
			if (cen)
				cen_cnt <= (cen_cnt >= cen_lim) ? 3'd0 : cen_cnt + 3'd1;
		end
	end

	// global registers
	always_ff @(posedge clk) begin
		if (rst) begin
			sel_reg <= 8'h00;
			div     <= fm_pkg::div_by_6;
			tcfg    <= '0;
		end else begin
			tcfg.clr_a <= 1'b0;
			tcfg.clr_b <= 1'b0;
			if (addr_xfer)
				sel_reg <= wr.data;
			if (data_xfer) begin
				case (sel_reg)
					fm_pkg::timer_a_hi: tcfg.value_a[9:2] <= wr.data;
					fm_pkg::timer_a_lo: tcfg.value_a[1:0] <= wr.data[1:0];
					fm_pkg::timer_b:    tcfg.value_b      <= wr.data;
					fm_pkg::timer_ctl: begin
						{tcfg.clr_b, tcfg.clr_a} <= wr.data[5:4];
						{tcfg.en_irq_b, tcfg.en_irq_a} <= wr.data[3:2];
						{tcfg.load_b, tcfg.load_a} <= wr.data[1:0];
					end
					fm_pkg::div_6: div <= fm_pkg::div_by_6;
					fm_pkg::div_3: div <= fm_pkg::div_by_3;
					fm_pkg::div_2: div <= fm_pkg::div_by_2;
					default: ;
				endcase
			end
		end
	end

	// update strobes for the store
	always_ff @(posedge clk) begin
		if (rst) begin
			upd_valid <= 1'b0;
			kon_valid <= 1'b0;
		end else begin
			upd_valid <= data_xfer && (field != fm_pkg::fld_none);
			kon_valid <= data_xfer && (sel_reg == fm_pkg::key_on) &&
				(wr.data[1:0] != 2'b11); // codes 3 and 7 unused
		end
	end

	always_ff @(posedge clk) begin
		if (data_xfer) begin
			upd.field <= field;
			upd.ch    <= bank_ch(wr.bank, sel_reg[1:0]);
			upd.op    <= sel_reg[3:2];
			upd.data  <= wr.data;
			kon_ch    <= bank_ch(wr.data[2], wr.data[1:0]);
			kon_bits  <= wr.data[7:4];
		end
	end

	// busy window after each data byte
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ready <= 1'b1;
			busy_cnt <= '0;
		end else if (data_xfer) begin
			wr_ready <= 1'b0;
			busy_cnt <= BUSY_W'(BUSY_CYCLES - 1);
		end else if (!wr_ready) begin
			if (busy_cnt == '0)
				wr_ready <= 1'b1;
			else
				busy_cnt <= busy_cnt - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/fm_pkg.sv
// ####################################################################
// fm control package: register map, voice parameter and timer types
// ####################################################################
`default_nettype none

package fm_pkg;

	// fixed by the register map
	localparam int num_ch    = 6;
	localparam int num_op    = 4;
	localparam int num_slots = 24;

	typedef enum logic [7:0] {
		timer_a_hi = 8'h24,
		timer_a_lo = 8'h25,
		timer_b    = 8'h26,
		timer_ctl  = 8'h27,
		key_on     = 8'h28,
		div_6      = 8'h2D,
		div_3      = 8'h2E,
		div_2      = 8'h2F
	} glb_reg_e;

	typedef enum logic [1:0] {
		div_by_6,
		div_by_3,
		div_by_2
	} div_e;

	typedef enum logic [3:0] {
		fld_none,
		fld_dt1_mul,       // 0x3x
		fld_tl,            // 0x4x
		fld_ks_ar,         // 0x5x
		fld_d1r,           // 0x6x
		fld_d2r,           // 0x7x
		fld_d1l_rr,        // 0x8x
		fld_fnum_lo,       // A0-A2
		fld_block_fnum_hi, // A4-A6
		fld_fb_alg         // B0-B2
	} param_field_e;

	typedef struct packed {
		logic       is_data; // 0 = address byte
		logic       bank;    // 1 = channels 3..5
		logic [7:0] data;
	} host_wr_t;

	typedef struct packed {
		param_field_e field;
		logic [2:0]   ch;
		logic [1:0]   op;
		logic [7:0]   data;
	} param_upd_t;

	typedef struct packed {
		logic [2:0] dt1;
		logic [3:0] mul;
		logic [6:0] tl;
		logic [1:0] ks;
		logic [4:0] ar;
		logic [4:0] d1r;
		logic [4:0] d2r;
		logic [3:0] d1l;
		logic [3:0] rr;
	} op_params_t;

	typedef struct packed {
		logic [10:0] fnum;
		logic [2:0]  block;
		logic [2:0]  fb;
		logic [2:0]  alg;
	} ch_params_t;

	typedef struct packed {
		logic [2:0] ch;
		logic [1:0] op;
		logic       keyon;
		op_params_t opp;
		ch_params_t chp;
	} slot_out_t;

	typedef struct packed {
		logic [9:0] value_a;
		logic [7:0] value_b;
		logic       load_a;
		logic       load_b;
		logic       en_irq_a;
		logic       en_irq_b;
		logic       clr_a; // one-cycle pulses
		logic       clr_b;
	} timer_cfg_t;

	typedef struct packed {
		logic flag_a;
		logic flag_b;
	} timer_stat_t;

endpackage

`default_nettype wire
